/* build.f */
+incdir+hdl
hdl/astro_pkg.sv
hdl/uc_rodada.sv
hdl/banco_tiros.sv
hdl/banco_asteroides.sv
hdl/detector_colisoes.sv
hdl/placar.sv
hdl/astro_genius.sv
testbench/clock_gen.sv
testbench/astro_monitor.sv
testbench/astro_sva.sv
testbench/tb_astro_genius.sv

/* Bender.yml */
package:
  name: astro_genius

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/astro_pkg.sv
      - hdl/uc_rodada.sv
      - hdl/banco_tiros.sv
      - hdl/banco_asteroides.sv
      - hdl/detector_colisoes.sv
      - hdl/placar.sv
      - hdl/astro_genius.sv
  - target: test
    files:
      - testbench/clock_gen.sv
      - testbench/astro_monitor.sv
      - testbench/astro_sva.sv
      - testbench/tb_astro_genius.sv

/* testbench/tb_astro_genius.sv */
module tb_astro_genius import astro_pkg::*; ();

    localparam int NUM_TESTS = 23;
    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic        tiro;
        dir_t        dir;
        logic        ini;
        vidas_t      vidas;
        conta_aste_t aste;
        logic        pronto;
    } row_t;

    // fire, direction, iniciar first, expected lives, asteroids left, game over
    localparam row_t rows [NUM_TESTS] = '{
        // no shots, asteroid 0 reaches the ship on round 4, 1 and 2 together on round 5
        '{1'b0, cima, 1'b0, 2'd3, 3'd4, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd4, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd4, 1'b0},
        '{1'b0, cima, 1'b0, 2'd2, 3'd3, 1'b0},
        '{1'b0, cima, 1'b0, 2'd0, 3'd1, 1'b1},
        '{1'b1, cima, 1'b0, 2'd0, 3'd1, 1'b1},
        // four shots fill the bank, the fifth would have stopped asteroid 2
        '{1'b1, direita, 1'b1, 2'd3, 3'd4, 1'b0},
        '{1'b1, direita, 1'b0, 2'd3, 3'd4, 1'b0},
        '{1'b1, direita, 1'b0, 2'd3, 3'd4, 1'b0},
        '{1'b1, direita, 1'b0, 2'd2, 3'd3, 1'b0},
        '{1'b1, esquerda, 1'b0, 2'd0, 3'd1, 1'b1},
        // shots take asteroids 0, 1 and 2, then one shot runs off the left edge
        '{1'b1, cima, 1'b1, 2'd3, 3'd4, 1'b0},
        '{1'b1, baixo, 1'b0, 2'd3, 3'd3, 1'b0},
        '{1'b1, esquerda, 1'b0, 2'd3, 3'd2, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b1, esquerda, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0},
        '{1'b0, cima, 1'b0, 2'd3, 3'd1, 1'b0}
    };

    logic clock;
    logic rst;
    logic iniciar;
    logic cmd_valid;
    logic cmd_tiro;
    dir_t cmd_dir;
    logic res_ready;
    logic cmd_ready;
    logic res_valid;
    vidas_t res_vidas;
    conta_aste_t res_aste_restantes;
    logic pronto;

    int test_id;
    vidas_t exp_vidas;
    conta_aste_t exp_aste;
    logic exp_pronto;
    logic fim;
    int checked;
    int errors;
    logic [15:0] lfsr;

    clock_gen clock_gen (.clock(clock), .rst(rst));

    astro_genius uut (.*);

    astro_monitor monitor (.*);

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    // one LFSR step per cycle gives the res_ready bit
    initial begin
        lfsr = 16'd30779;
        res_ready = 1'b0;
        forever begin
            @(posedge clock);
            #10;
            lfsr = lfsr_step(lfsr);
            res_ready = lfsr[0];
        end
    end

    task automatic drive_round(input int k, output logic ok);
        int waited;
        ok = 1'b1;
        if (rows[k].ini) begin
            iniciar = 1'b1;
            @(posedge clock);
            #10;
            iniciar = 1'b0;
        end
        cmd_valid = 1'b1;
        cmd_tiro = rows[k].tiro;
        cmd_dir = rows[k].dir;
        test_id = k;
        exp_vidas = rows[k].vidas;
        exp_aste = rows[k].aste;
        exp_pronto = rows[k].pronto;
        waited = 0;
        @(negedge clock);
        while (!cmd_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clock);
        end
        if (!cmd_ready) begin
            ok = 1'b0;
        end else begin
            @(posedge clock);
            #10;
            cmd_valid = 1'b0;
            waited = 0;
            @(negedge clock);
            while (!(res_valid && res_ready) && waited < WAIT_LIMIT) begin
                waited++;
                @(negedge clock);
            end
            if (!(res_valid && res_ready)) begin
                ok = 1'b0;
            end else begin
                @(posedge clock);
                #10;
            end
        end
    endtask

    initial begin
        int waited;
        int k;
        int fails;
        logic ok;
        iniciar = 1'b0;
        cmd_valid = 1'b0;
        cmd_tiro = 1'b0;
        cmd_dir = cima;
        test_id = 0;
        exp_vidas = '0;
        exp_aste = '0;
        exp_pronto = 1'b0;
        fim = 1'b0;
        ok = 1'b1;
        k = 0;
        waited = 0;
        @(posedge clock);
        while (rst !== 1'b0 && waited < 10) begin
            waited++;
            @(posedge clock);
        end
        if (rst !== 1'b0) begin
            $display("reset was never released");
            ok = 1'b0;
        end else begin
            #10;
            while (ok && k < NUM_TESTS) begin
                drive_round(k, ok);
                if (ok) begin
                    k++;
                end else begin
                    $display("no handshake from the DUT within %0d cycles in test %0d",
                        WAIT_LIMIT, k);
                end
            end
        end
        fim = 1'b1;
        #1;
        fails = errors + uut.props.reset_fails + uut.props.hold_fails
            + uut.props.overlap_fails;
        if (ok && fails == 0 && checked == NUM_TESTS) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/astro_sva.sv */
module astro_sva import astro_pkg::*; (
    input logic        clock,
    input logic        rst,
    input logic        cmd_ready,
    input logic        res_valid,
    input logic        res_ready,
    input vidas_t      res_vidas,
    input conta_aste_t res_aste_restantes,
    input logic        pronto
);

    int reset_fails = 0;
    int hold_fails = 0;
    int overlap_fails = 0;

    no_result_after_reset: assert property (@(posedge clock) rst |=> !res_valid)
        else begin
            reset_fails++;
            $error("res_valid high in the cycle after reset");
        end

    // a stalled result keeps its values
    result_holds: assert property (@(posedge clock) disable iff (rst)
        res_valid && !res_ready |=> res_valid && $stable(res_vidas)
            && $stable(res_aste_restantes) && $stable(pronto))
        else begin
            hold_fails++;
            $error("result changed or dropped while res_ready was low");
        end

    // only one round in flight
    ready_or_result: assert property (@(posedge clock) disable iff (rst)
        !(cmd_ready && res_valid))
        else begin
            overlap_fails++;
            $error("cmd_ready and res_valid high together");
        end

endmodule

bind astro_genius astro_sva props (.*);

/* testbench/astro_monitor.sv */
module astro_monitor import astro_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        res_valid,
    input  logic        res_ready,
    input  vidas_t      res_vidas,
    input  conta_aste_t res_aste_restantes,
    input  logic        pronto,
    input  int          test_id,
    input  vidas_t      exp_vidas,
    input  conta_aste_t exp_aste,
    input  logic        exp_pronto,
    input  logic        fim,
    output int          checked,
    output int          errors
);

    int n_checked = 0;
    int n_errors = 0;

    assign checked = n_checked;
    assign errors = n_errors;

    // mid-cycle sample, the transfer happens on the next rising edge
    always @(negedge clock) begin
        if (!rst && res_valid && res_ready) begin
            n_checked = n_checked + 1;
            if (res_vidas !== exp_vidas || res_aste_restantes !== exp_aste
                    || pronto !== exp_pronto) begin
                n_errors = n_errors + 1;
                $display("error at time %0t: test %0d got %0d/%0d/%0b, expected %0d/%0d/%0b",
                    $time, test_id, res_vidas, res_aste_restantes, pronto,
                    exp_vidas, exp_aste, exp_pronto);
            end else begin
                $display("test %0d ok: lives %0d, asteroids %0d, pronto %0b",
                    test_id, res_vidas, res_aste_restantes, pronto);
            end
        end
    end

    always @(posedge fim) begin
        $display("totals: %0d results checked, %0d mismatches", n_checked, n_errors);
    end

endmodule

/* testbench/clock_gen.sv */
module clock_gen (
    output logic clock,
    output logic rst
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // reset released a little after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clock);
        #10;
        rst = 1'b0;
    end

endmodule

/* hdl/astro_genius.sv */
`include "astro_macros.svh"

module astro_genius import astro_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        iniciar,
    input  logic        cmd_valid,
    input  logic        cmd_tiro,
    input  dir_t        cmd_dir,
    input  logic        res_ready,
    output logic        cmd_ready,
    output logic        res_valid,
    output vidas_t      res_vidas,
    output conta_aste_t res_aste_restantes,
    output logic        pronto
);

    // round sequencer strobes
    logic carrega_inicio;
    logic registra_tiro;
    dir_t dir_tiro;
    logic move_tiros;
    logic aplica_acertos;
    logic move_aste;
    logic aplica_nave;
    logic fecha_rodada;
    logic res_livre;

    coord_t tiro_x [`ASTRO_NUM_SLOTS];
    coord_t tiro_y [`ASTRO_NUM_SLOTS];
    coord_t aste_x [`ASTRO_NUM_SLOTS];
    coord_t aste_y [`ASTRO_NUM_SLOTS];
    slot_mask_t tiro_loaded;
    slot_mask_t aste_loaded;

    // hit masks
    slot_mask_t acerto_tiros;
    slot_mask_t acerto_aste;
    slot_mask_t acerto_nave;

    uc_rodada uc_rodada (.*);

    banco_tiros banco_tiros (.*);

    banco_asteroides banco_asteroides (.*);

    detector_colisoes detector_colisoes (.*);

    placar placar (.*);

endmodule

/* hdl/placar.sv */
`include "astro_macros.svh"

module placar import astro_pkg::*; (
    input  logic        clock,
    input  logic        rst,
    input  logic        carrega_inicio,
    input  logic        aplica_nave,
    input  slot_mask_t  acerto_nave,
    input  slot_mask_t  aste_loaded,
    input  logic        fecha_rodada,
    input  logic        res_ready,
    output logic        res_valid,
    output vidas_t      res_vidas,
    output conta_aste_t res_aste_restantes,
    output logic        pronto,
    output logic        res_livre
);

    vidas_t vidas;
    conta_aste_t n_nave;
    conta_aste_t n_aste;

    assign n_nave = conta_bits(acerto_nave);
    assign n_aste = conta_bits(aste_loaded);

    // lives saturate at zero
    always_ff @(posedge clock) begin
        if (rst || carrega_inicio) begin
            vidas <= `ASTRO_VIDAS_INI;
        end else if (aplica_nave) begin
            if (n_nave >= {1'b0, vidas}) begin
                vidas <= '0;
            end else begin
                vidas <= vidas - vidas_t'(n_nave);
            end
        end
    end

    assign pronto = (vidas == '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (fecha_rodada) begin
            res_valid <= 1'b1;
        end else if (res_livre) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (fecha_rodada) begin
            res_vidas <= vidas;
            res_aste_restantes <= n_aste;
        end
    end

    // result taken on this edge
    assign res_livre = res_valid && res_ready;

endmodule

/* hdl/detector_colisoes.sv */
`include "astro_macros.svh"

module detector_colisoes import astro_pkg::*; (
    input  coord_t     tiro_x [`ASTRO_NUM_SLOTS],
    input  coord_t     tiro_y [`ASTRO_NUM_SLOTS],
    input  slot_mask_t tiro_loaded,
    input  coord_t     aste_x [`ASTRO_NUM_SLOTS],
    input  coord_t     aste_y [`ASTRO_NUM_SLOTS],
    input  slot_mask_t aste_loaded,
    output slot_mask_t acerto_tiros,
    output slot_mask_t acerto_aste,
    output slot_mask_t acerto_nave
);

    slot_mask_t livres;

    always_comb begin
        for (int j = 0; j < `ASTRO_NUM_SLOTS; j++) begin
            acerto_nave[j] = aste_loaded[j] && (aste_x[j] == `ASTRO_NAVE_X)
                && (aste_y[j] == `ASTRO_NAVE_Y);
        end
    end

    // ship is checked first, so those asteroids are not offered to shots
    always_comb begin
        acerto_tiros = '0;
        acerto_aste = '0;
        livres = aste_loaded & ~acerto_nave;
        for (int i = 0; i < `ASTRO_NUM_SLOTS; i++) begin
            for (int j = 0; j < `ASTRO_NUM_SLOTS; j++) begin
                if (tiro_loaded[i] && !acerto_tiros[i] && livres[j]
                        && (tiro_x[i] == aste_x[j]) && (tiro_y[i] == aste_y[j])) begin
                    acerto_tiros[i] = 1'b1;
                    acerto_aste[j] = 1'b1;
                    livres[j] = 1'b0;
                end
            end
        end
    end

endmodule

/* hdl/banco_asteroides.sv */
`include "astro_macros.svh"

module banco_asteroides import astro_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  logic       carrega_inicio,
    input  logic       move_aste,
    input  logic       aplica_acertos,
    input  logic       aplica_nave,
    input  slot_mask_t acerto_aste,
    input  slot_mask_t acerto_nave,
    output coord_t     aste_x [`ASTRO_NUM_SLOTS],
    output coord_t     aste_y [`ASTRO_NUM_SLOTS],
    output slot_mask_t aste_loaded
);

    localparam coord_t ini_x [`ASTRO_NUM_SLOTS] = '{
        `ASTRO_ASTE_INI_X0, `ASTRO_ASTE_INI_X1, `ASTRO_ASTE_INI_X2, `ASTRO_ASTE_INI_X3
    };
    localparam coord_t ini_y [`ASTRO_NUM_SLOTS] = '{
        `ASTRO_ASTE_INI_Y0, `ASTRO_ASTE_INI_Y1, `ASTRO_ASTE_INI_Y2, `ASTRO_ASTE_INI_Y3
    };
    // asteroids keep their heading for the whole game
    localparam dir_t ini_d [`ASTRO_NUM_SLOTS] = '{
        dir_t'(`ASTRO_ASTE_INI_D0), dir_t'(`ASTRO_ASTE_INI_D1),
        dir_t'(`ASTRO_ASTE_INI_D2), dir_t'(`ASTRO_ASTE_INI_D3)
    };

    slot_mask_t limpa;

    assign limpa = (aplica_acertos ? acerto_aste : '0) | (aplica_nave ? acerto_nave : '0);

    always_ff @(posedge clock) begin
        for (int i = 0; i < `ASTRO_NUM_SLOTS; i++) begin
            if (rst || carrega_inicio) begin
                aste_x[i] <= ini_x[i];
                aste_y[i] <= ini_y[i];
            end else if (move_aste) begin
                aste_x[i] <= aste_x[i] + delta_x(ini_d[i]);
                aste_y[i] <= aste_y[i] + delta_y(ini_d[i]);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst || carrega_inicio) begin
            aste_loaded <= '1;
        end else begin
            aste_loaded <= aste_loaded & ~limpa;
        end
    end

endmodule

/* hdl/banco_tiros.sv */
`include "astro_macros.svh"

module banco_tiros import astro_pkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  logic       carrega_inicio,
    input  logic       registra_tiro,
    input  dir_t       dir_tiro,
    input  logic       move_tiros,
    input  logic       aplica_acertos,
    input  slot_mask_t acerto_tiros,
    output coord_t     tiro_x [`ASTRO_NUM_SLOTS],
    output coord_t     tiro_y [`ASTRO_NUM_SLOTS],
    output slot_mask_t tiro_loaded
);

    dir_t tiro_d [`ASTRO_NUM_SLOTS];
    slot_mask_t livre;
    slot_mask_t novo;
    slot_mask_t na_borda;

    // lowest free slot, one-hot
    assign livre = ~tiro_loaded;
    assign novo = livre & (~livre + 1'b1);

    always_comb begin
        for (int i = 0; i < `ASTRO_NUM_SLOTS; i++) begin
            case (tiro_d[i])
                cima: na_borda[i] = (tiro_y[i] == `ASTRO_BORDA_MIN);
                baixo: na_borda[i] = (tiro_y[i] == `ASTRO_BORDA_MAX);
                direita: na_borda[i] = (tiro_x[i] == `ASTRO_BORDA_MAX);
                default: na_borda[i] = (tiro_x[i] == `ASTRO_BORDA_MIN);
            endcase
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `ASTRO_NUM_SLOTS; i++) begin
            if (registra_tiro && novo[i]) begin
                tiro_x[i] <= `ASTRO_NAVE_X;
                tiro_y[i] <= `ASTRO_NAVE_Y;
                tiro_d[i] <= dir_tiro;
            end else if (move_tiros) begin
                tiro_x[i] <= tiro_x[i] + delta_x(tiro_d[i]);
                tiro_y[i] <= tiro_y[i] + delta_y(tiro_d[i]);
            end
        end
    end

    // a full bank simply drops the shot
    always_ff @(posedge clock) begin
        if (rst || carrega_inicio) begin
            tiro_loaded <= '0;
        end else if (registra_tiro) begin
            tiro_loaded <= tiro_loaded | novo;
        end else if (move_tiros) begin
            tiro_loaded <= tiro_loaded & ~na_borda;
        end else if (aplica_acertos) begin
            tiro_loaded <= tiro_loaded & ~acerto_tiros;
        end
    end

endmodule

/* hdl/uc_rodada.sv */
module uc_rodada import astro_pkg::*; (
    input  logic clock,
    input  logic rst,
    input  logic iniciar,
    input  logic cmd_valid,
    input  logic cmd_tiro,
    input  dir_t cmd_dir,
    input  logic pronto,
    input  logic res_livre,
    output logic cmd_ready,
    output logic carrega_inicio,
    output logic registra_tiro,
    output dir_t dir_tiro,
    output logic move_tiros,
    output logic aplica_acertos,
    output logic move_aste,
    output logic aplica_nave,
    output logic fecha_rodada
);

    estado_rodada_t estado;
    estado_rodada_t proximo;
    logic tiro_q;
    logic fechado;
    logic aceita;
    logic ativo;

    assign cmd_ready = (estado == ocioso) && !iniciar;
    assign aceita = cmd_valid && cmd_ready;
    assign carrega_inicio = (estado == ocioso) && iniciar;

    // game over freezes the field, the round still reports
    assign ativo = !pronto;

    // state names shadowed by port names need the package scope
    always_comb begin
        proximo = estado;
        case (estado)
            ocioso: begin
                if (aceita) begin
                    proximo = registra;
                end
            end
            registra: proximo = astro_pkg::move_tiros;
            astro_pkg::move_tiros: proximo = compara_tiros;
            compara_tiros: proximo = astro_pkg::move_aste;
            astro_pkg::move_aste: proximo = compara_nave;
            compara_nave: proximo = resultado;
            resultado: begin
                if (fechado && res_livre) begin
                    proximo = ocioso;
                end
            end
            default: proximo = ocioso;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            estado <= ocioso;
            fechado <= 1'b0;
        end else begin
            estado <= proximo;
            fechado <= (estado == resultado) && (proximo == resultado);
        end
    end

    // command latch
    always_ff @(posedge clock) begin
        if (aceita) begin
            tiro_q <= cmd_tiro;
            dir_tiro <= cmd_dir;
        end
    end

    assign registra_tiro = (estado == registra) && tiro_q && ativo;
    assign move_tiros = (estado == astro_pkg::move_tiros) && ativo;
    assign aplica_acertos = ((estado == compara_tiros) || (estado == compara_nave)) && ativo;
    assign move_aste = (estado == astro_pkg::move_aste) && ativo;
    assign aplica_nave = (estado == compara_nave) && ativo;
    assign fecha_rodada = (estado == resultado) && !fechado;

endmodule

/* hdl/astro_pkg.sv */
`include "astro_macros.svh"

package astro_pkg;

    typedef logic [3:0] coord_t;

    typedef enum logic [1:0] {
        cima,
        baixo,
        direita,
        esquerda
    } dir_t;

    typedef logic [`ASTRO_NUM_SLOTS-1:0] slot_mask_t;
    typedef logic [1:0] vidas_t;
    typedef logic [2:0] conta_aste_t;

    typedef enum logic [2:0] {
        ocioso,
        registra,
        move_tiros,
        compara_tiros,
        move_aste,
        compara_nave,
        resultado
    } estado_rodada_t;

    // one cell step, 4-bit add wraps modulo 16
    function automatic coord_t delta_x(dir_t d);
        case (d)
            direita: return 4'd1;
            esquerda: return 4'hf;
            default: return 4'd0;
        endcase
    endfunction

    function automatic coord_t delta_y(dir_t d);
        case (d)
            baixo: return 4'd1;
            cima: return 4'hf;
            default: return 4'd0;
        endcase
    endfunction

    function automatic conta_aste_t conta_bits(slot_mask_t m);
        conta_aste_t n;
        n = '0;
        for (int i = 0; i < `ASTRO_NUM_SLOTS; i++) begin
            n = n + conta_aste_t'(m[i]);
        end
        return n;
    endfunction

endpackage

/* hdl/astro_macros.svh */
`ifndef ASTRO_MACROS_SVH
`define ASTRO_MACROS_SVH

`define ASTRO_NUM_SLOTS 4

// ship sits fixed in the middle of the field
`define ASTRO_NAVE_X 4'd7
`define ASTRO_NAVE_Y 4'd7

`define ASTRO_VIDAS_INI 2'd3

`define ASTRO_BORDA_MIN 4'd0
`define ASTRO_BORDA_MAX 4'd15

// start table, directions coded as cima 0, baixo 1, direita 2, esquerda 3
`define ASTRO_ASTE_INI_X0 4'd7
`define ASTRO_ASTE_INI_Y0 4'd3
`define ASTRO_ASTE_INI_D0 2'd1
`define ASTRO_ASTE_INI_X1 4'd7
`define ASTRO_ASTE_INI_Y1 4'd12
`define ASTRO_ASTE_INI_D1 2'd0
`define ASTRO_ASTE_INI_X2 4'd2
`define ASTRO_ASTE_INI_Y2 4'd7
`define ASTRO_ASTE_INI_D2 2'd2
`define ASTRO_ASTE_INI_X3 4'd12
`define ASTRO_ASTE_INI_Y3 4'd0
`define ASTRO_ASTE_INI_D3 2'd3

`endif
